//--- source/sink_defs.svh
// Widths and depths shared by the memory write streamer
// Addresses are byte addresses; writes are always whole words
// SINK_DATA_W must be a multiple of 8 so that byte enables fit
// The address FIFO depth is only a default and can be overridden per instance

`ifndef SINK_DEFS_SVH
`define SINK_DEFS_SVH

// Payload width of one stream beat and one memory word
`define SINK_DATA_W 32

// Byte address width on the memory port
`define SINK_ADDR_W 32

// Width of the job word count and of the beat index
`define SINK_LEN_W 16

// Addresses generated ahead of the data beats
`define SINK_ADDR_FIFO_DEPTH 2

`endif

//--- source/sink_pkg.sv
// Types shared by the memory write streamer
// Widths come from sink_defs.svh
// The wen bit of mem_req_t is always low here, since the streamer only writes

`include "sink_defs.svh"

package sink_pkg;

  typedef logic [`SINK_DATA_W-1:0]   data_t;
  typedef logic [`SINK_ADDR_W-1:0]   addr_t;
  typedef logic [`SINK_DATA_W/8-1:0] strb_t;
  typedef logic [`SINK_LEN_W-1:0]    len_t;

  // Streamer control states
  typedef enum logic [1:0] {
    SINK_IDLE    = 2'd0,
    SINK_WORKING = 2'd1,
    SINK_DRAIN   = 2'd2
  } sink_state_e;

  // One beat on the incoming valid/ready stream
  typedef struct packed {
    data_t data;
    strb_t strb;
  } stream_beat_t;

  // Job description, sampled when start is seen in idle
  typedef struct packed {
    logic  start;
    addr_t base_addr;
    addr_t stride;
    len_t  length;
  } sink_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
    logic addr_done;
  } sink_flags_t;

  // Write request on the req/gnt memory port
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t be;
    logic  wen;
  } mem_req_t;

endpackage

//--- source/sink_addr_gen.sv
// One-dimensional address generator: base + i * stride for i = 0 .. length-1
// The job is latched when start_i is seen with enable_i high
// Low two address bits are forced to zero, so a stride that is not a word
// multiple still yields word-aligned addresses
// done_o stays high from the last accepted address until clear_i

`timescale 1ns/1ps

module sink_addr_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 enable_i,
  input  logic                 start_i,
  input  sink_pkg::sink_ctrl_t ctrl_i,
  input  logic                 addr_ready_i,
  output logic                 addr_valid_o,
  output sink_pkg::addr_t      addr_o,
  output logic                 done_o
);

  import sink_pkg::*;

  addr_t addr_q;
  addr_t stride_q;
  len_t  len_q;
  len_t  idx_q;
  logic  active_q;
  logic  step;

  // An address is offered while the job still has indices left
  assign addr_valid_o = enable_i & active_q & (idx_q != len_q);
  assign step         = addr_valid_o & addr_ready_i;

  // Also true right away for a job of length zero
  assign done_o = active_q & (idx_q == len_q);

  assign addr_o = {addr_q[$bits(addr_t)-1:2], 2'b00};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (step) begin
        idx_q <= idx_q + len_t'(1);
      end
    end
  end

  // Job parameters and the running address
  always_ff @(posedge clk_i) begin
    if (enable_i && start_i) begin
      addr_q   <= ctrl_i.base_addr;
      stride_q <= ctrl_i.stride;
      len_q    <= ctrl_i.length;
    end else if (step) begin
      addr_q <= addr_q + stride_q;
    end
  end

endmodule

//--- source/sink_addr_fifo.sv
// Circular address FIFO between the generator and the request stage
// A push is accepted when full if a pop happens in the same cycle
// pop_addr_o is only meaningful while pop_valid_o is high

`timescale 1ns/1ps

`include "sink_defs.svh"

module sink_addr_fifo #(
  parameter int unsigned DEPTH = `SINK_ADDR_FIFO_DEPTH
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  logic            push_valid_i,
  input  sink_pkg::addr_t push_addr_i,
  output logic            push_ready_o,
  input  logic            pop_i,
  output logic            pop_valid_o,
  output sink_pkg::addr_t pop_addr_o
);

  import sink_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  addr_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  assign pop_valid_o  = (cnt_q != '0);
  assign pop_addr_o   = mem_q[rd_ptr_q];
  assign push_ready_o = (cnt_q != CNT_W'(DEPTH)) | pop_i;

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_i & pop_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Simultaneous push and pop leaves the occupancy unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_addr_i;
    end
  end

endmodule

//--- source/sink_ctrl_fsm.sv
// Job sequencing for the streamer: IDLE -> WORKING -> DRAIN -> IDLE
// A start seen outside IDLE is ignored
// busy_o is high only while a job runs and enable_i is high
// done_o is a registered single-cycle pulse after the return to IDLE

`timescale 1ns/1ps

module sink_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic enable_i,
  input  logic start_i,
  input  logic addr_done_i,
  input  logic len_reached_i,
  output logic gen_start_o,
  output logic gen_enable_o,
  output logic gen_clear_o,
  output logic cnt_clear_o,
  output logic busy_o,
  output logic ready_start_o,
  output logic done_o
);

  import sink_pkg::*;

  sink_state_e state_q;
  sink_state_e state_d;
  logic        end_of_job;
  logic        done_q;

  always_comb begin
    state_d    = state_q;
    end_of_job = 1'b0;
    case (state_q)
      SINK_IDLE: begin
        if (start_i) begin
          state_d = SINK_WORKING;
        end
      end
      SINK_WORKING: begin
        if (addr_done_i) begin
          state_d = SINK_DRAIN;
        end
      end
      SINK_DRAIN: begin
        // Every address has been paired with a beat
        if (len_reached_i) begin
          state_d    = SINK_IDLE;
          end_of_job = enable_i;
        end
      end
      default: state_d = SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SINK_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= end_of_job & ~clear_i;
      if (clear_i) begin
        state_q <= SINK_IDLE;
      end else if (enable_i) begin
        state_q <= state_d;
      end
    end
  end

  assign gen_start_o  = enable_i & (state_q == SINK_IDLE) & start_i;
  assign gen_enable_o = enable_i & ((state_q != SINK_IDLE) | start_i);

  // Generator and counter are reset together when the job ends
  assign gen_clear_o = clear_i | end_of_job;
  // Counter also clears on start, which latches the new length
  assign cnt_clear_o = clear_i | end_of_job | gen_start_o;

  assign busy_o        = enable_i & (state_q != SINK_IDLE);
  assign ready_start_o = (state_q == SINK_IDLE);
  assign done_o        = done_q;

endmodule

//--- source/sink_xfer_counter.sv
// Counts accepted beats of the current job
// length_i is latched on clear_i, so clear must be given when the job starts

`timescale 1ns/1ps

module sink_xfer_counter (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  logic           enable_i,
  input  logic           inc_i,
  input  sink_pkg::len_t length_i,
  output sink_pkg::len_t count_o,
  output logic           len_reached_o
);

  import sink_pkg::*;

  len_t count_q;
  len_t len_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      len_q   <= '0;
    end else if (clear_i) begin
      count_q <= '0;
      len_q   <= length_i;
    end else if (enable_i && inc_i) begin
      count_q <= count_q + len_t'(1);
    end
  end

  assign count_o       = count_q;
  assign len_reached_o = (count_q == len_q);

endmodule

//--- source/sink_req_stage.sv
// One-entry write request register toward the req/gnt memory port
// A request stays stable until the grant; a new beat may load in the
// granting cycle, so back-to-back writes need no idle cycle
// clear_i drops a pending request without waiting for its grant

`timescale 1ns/1ps

module sink_req_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   active_i,
  input  logic                   stream_valid_i,
  input  sink_pkg::stream_beat_t stream_beat_i,
  input  logic                   addr_valid_i,
  input  sink_pkg::addr_t        addr_i,
  input  logic                   mem_gnt_i,
  output logic                   accept_o,
  output logic                   mem_req_o,
  output sink_pkg::mem_req_t     mem_req_data_o
);

  import sink_pkg::*;

  logic     full_q;
  mem_req_t req_q;

  // Single transfer condition for stream ready, FIFO pop and beat count
  assign accept_o = active_i & stream_valid_i & addr_valid_i & (~full_q | mem_gnt_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (clear_i) begin
      full_q <= 1'b0;
    end else if (accept_o) begin
      full_q <= 1'b1;
    end else if (mem_gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      req_q.addr <= addr_i;
      req_q.data <= stream_beat_i.data;
      req_q.be   <= stream_beat_i.strb;
      req_q.wen  <= 1'b0;
    end
  end

  assign mem_req_o      = full_q;
  assign mem_req_data_o = req_q;

endmodule

//--- source/sink_top.sv
// Memory write streamer: writes stream beats to base + i * stride
// ctrl_i is sampled when start is seen in idle; a start while busy is ignored
// The memory port has no response phase, a write ends at req and gnt
// The last write may still be pending when flags_o.done pulses

`timescale 1ns/1ps

`include "sink_defs.svh"

module sink_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  logic                   stream_valid_i,
  input  sink_pkg::stream_beat_t stream_beat_i,
  output logic                   stream_ready_o,
  output logic                   mem_req_o,
  output sink_pkg::mem_req_t     mem_req_data_o,
  input  logic                   mem_gnt_i,
  input  sink_pkg::sink_ctrl_t   ctrl_i,
  output sink_pkg::sink_flags_t  flags_o
);

  import sink_pkg::*;

  logic  gen_start;
  logic  gen_enable;
  logic  gen_clear;
  logic  cnt_clear;
  logic  busy;
  logic  addr_done;
  logic  len_reached;
  logic  gen_addr_valid;
  addr_t gen_addr;
  logic  fifo_push_ready;
  logic  fifo_addr_valid;
  addr_t fifo_addr;
  logic  accept;

  sink_ctrl_fsm i_ctrl_fsm (
    .clk_i         ( clk_i               ),
    .rst_ni        ( rst_ni              ),
    .clear_i       ( clear_i             ),
    .enable_i      ( enable_i            ),
    .start_i       ( ctrl_i.start        ),
    .addr_done_i   ( addr_done           ),
    .len_reached_i ( len_reached         ),
    .gen_start_o   ( gen_start           ),
    .gen_enable_o  ( gen_enable          ),
    .gen_clear_o   ( gen_clear           ),
    .cnt_clear_o   ( cnt_clear           ),
    .busy_o        ( busy                ),
    .ready_start_o ( flags_o.ready_start ),
    .done_o        ( flags_o.done        )
  );

  sink_addr_gen i_addr_gen (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( gen_clear       ),
    .enable_i     ( gen_enable      ),
    .start_i      ( gen_start       ),
    .ctrl_i       ( ctrl_i          ),
    .addr_ready_i ( fifo_push_ready ),
    .addr_valid_o ( gen_addr_valid  ),
    .addr_o       ( gen_addr        ),
    .done_o       ( addr_done       )
  );

  assign flags_o.addr_done = addr_done;

  sink_addr_fifo #(
    .DEPTH ( `SINK_ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( gen_addr_valid  ),
    .push_addr_i  ( gen_addr        ),
    .push_ready_o ( fifo_push_ready ),
    .pop_i        ( accept          ),
    .pop_valid_o  ( fifo_addr_valid ),
    .pop_addr_o   ( fifo_addr       )
  );

  // Beat count itself is left open, only the length match is needed
  sink_xfer_counter i_xfer_counter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( cnt_clear     ),
    .enable_i      ( enable_i      ),
    .inc_i         ( accept        ),
    .length_i      ( ctrl_i.length ),
    .count_o       (               ),
    .len_reached_o ( len_reached   )
  );

  sink_req_stage i_req_stage (
    .clk_i          ( clk_i           ),
    .rst_ni         ( rst_ni          ),
    .clear_i        ( clear_i         ),
    .active_i       ( busy            ),
    .stream_valid_i ( stream_valid_i  ),
    .stream_beat_i  ( stream_beat_i   ),
    .addr_valid_i   ( fifo_addr_valid ),
    .addr_i         ( fifo_addr       ),
    .mem_gnt_i      ( mem_gnt_i       ),
    .accept_o       ( accept          ),
    .mem_req_o      ( mem_req_o       ),
    .mem_req_data_o ( mem_req_data_o  )
  );

  assign stream_ready_o = accept;

endmodule

//--- bench/sink_assert.sv
// Concurrent checks on the streamer, bound into sink_top
// clear_i may drop a pending request, so stability is not required across it
// fail_cnt holds the number of assertion failures so far

`timescale 1ns/1ps

module sink_assert (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  stream_ready_i,
  input  logic                  mem_req_i,
  input  logic                  mem_gnt_i,
  input  sink_pkg::mem_req_t    mem_req_data_i,
  input  sink_pkg::sink_flags_t flags_i
);

  int n_req  = 0;
  int n_done = 0;
  int n_rdy  = 0;
  int n_idle = 0;
  int fail_cnt;

  assign fail_cnt = n_req + n_done + n_rdy + n_idle;

  // A pending request keeps address, data and strobes until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_gnt_i && !clear_i) |=> (mem_req_i && $stable(mem_req_data_i)))
  else begin
    $error("memory request changed or dropped before its grant");
    n_req++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.done |=> !flags_i.done)
  else begin
    $error("done is longer than one cycle");
    n_done++;
  end

  // ready_start comes back only with the done pulse or after a clear
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(flags_i.ready_start) |-> (flags_i.done || $past(clear_i)))
  else begin
    $error("ready_start high again before the job ended");
    n_rdy++;
  end

  // Nothing may be accepted while no job runs
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.ready_start |-> !stream_ready_i)
  else begin
    $error("stream ready high in idle");
    n_idle++;
  end

endmodule

bind sink_top sink_assert i_assert (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .clear_i        ( clear_i        ),
  .stream_ready_i ( stream_ready_o ),
  .mem_req_i      ( mem_req_o      ),
  .mem_gnt_i      ( mem_gnt_i      ),
  .mem_req_data_i ( mem_req_data_o ),
  .flags_i        ( flags_o        )
);

//--- bench/sink_tb.sv
// Testbench for the memory write streamer
// Jobs run one after another from a table; the testbench is both the stream
// source and a memory that grants writes with random stalls
// The enable input is held high for the whole run

`timescale 1ns/1ps

module sink_tb;

  import sink_pkg::*;

  localparam int          NUM_JOBS = 7;
  localparam logic [31:0] SEED     = 32'h998b;

  typedef struct packed {
    addr_t      base;
    addr_t      stride;
    len_t       length;
    logic [7:0] stall_pct;
    logic [7:0] gap_pct;
    len_t       clear_at;
    logic [7:0] poke_cyc;
  } job_t;

  logic         clk_i;
  logic         rst_ni;
  logic         clear_i;
  logic         enable_i;
  logic         stream_valid_i;
  stream_beat_t stream_beat_i;
  logic         stream_ready_o;
  logic         mem_req_o;
  mem_req_t     mem_req_data_o;
  logic         mem_gnt_i;
  sink_ctrl_t   ctrl_i;
  sink_flags_t  flags_o;

  job_t        jobs [NUM_JOBS];
  logic        table_ready;
  logic [31:0] src_rng;
  logic [31:0] mem_rng;
  logic [7:0]  stall_pct;
  logic        hold_gnt;
  logic        cleared;
  int          errors;
  int          tests_failed;
  int          done_total;
  int          assert_fails;
  addr_t       wr_addr_q [$];
  data_t       wr_data_q [$];
  strb_t       wr_strb_q [$];
  data_t       sent_data_q [$];
  strb_t       sent_strb_q [$];

  sink_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .stream_valid_i ( stream_valid_i ),
    .stream_beat_i  ( stream_beat_i  ),
    .stream_ready_o ( stream_ready_o ),
    .mem_req_o      ( mem_req_o      ),
    .mem_req_data_o ( mem_req_data_o ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Beat i goes to base + i * stride, rounded down to a word
  function automatic addr_t predict_addr(input job_t job, input int i);
    addr_t a;
    a = job.base + job.stride * addr_t'(i);
    a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic check_addr(input addr_t got, input addr_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_strb(input strb_t got, input strb_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_len(input len_t got, input len_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(input sink_flags_t got, input sink_flags_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Memory model; also counts done pulses
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o && mem_gnt_i) begin
        wr_addr_q.push_back(mem_req_data_o.addr);
        wr_data_q.push_back(mem_req_data_o.data);
        wr_strb_q.push_back(mem_req_data_o.be);
        check_bit(mem_req_data_o.wen, 1'b0, "mem_req_data_o.wen");
      end
      if (flags_o.done) begin
        done_total++;
      end
      @(posedge clk_i);
      #1;
      mem_rng = xorshift32(mem_rng);
      mem_gnt_i = !hold_gnt && ((mem_rng % 32'd100) >= 32'(stall_pct));
    end
  end

  // Grant is held low one cycle ahead so the pending request is dropped, not written
  task automatic clear_mid_job();
    stream_valid_i = 1'b0;
    hold_gnt = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    hold_gnt = 1'b0;
    cleared = 1'b1;
  endtask

  task automatic send_beats(input job_t job);
    logic fire;
    for (int i = 0; i < int'(job.length); i++) begin
      if (job.clear_at != '0 && i == int'(job.clear_at)) begin
        clear_mid_job();
        return;
      end
      src_rng = xorshift32(src_rng);
      while ((src_rng % 32'd100) < 32'(job.gap_pct)) begin
        stream_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
        src_rng = xorshift32(src_rng);
      end
      src_rng = xorshift32(src_rng);
      stream_beat_i.data = src_rng;
      src_rng = xorshift32(src_rng);
      stream_beat_i.strb = strb_t'(src_rng);
      sent_data_q.push_back(stream_beat_i.data);
      sent_strb_q.push_back(stream_beat_i.strb);
      stream_valid_i = 1'b1;
      fire = 1'b0;
      while (!fire) begin
        @(negedge clk_i);
        fire = stream_valid_i & stream_ready_o;
        @(posedge clk_i);
        #1;
      end
    end
    stream_valid_i = 1'b0;
  endtask

  // Checks ready_start each cycle and gives one start while busy at poke_cyc
  task automatic watch_job(input job_t job);
    int   cyc;
    logic finished;
    cyc = 0;
    finished = 1'b0;
    @(posedge clk_i);
    #1;
    ctrl_i.start = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      if (cleared) begin
        finished = 1'b1;
      end else if (flags_o.done) begin
        check_bit(flags_o.ready_start, 1'b1, "flags_o.ready_start at done");
        finished = 1'b1;
      end else begin
        check_bit(flags_o.ready_start, 1'b0, "flags_o.ready_start while busy");
      end
      if (!finished) begin
        @(posedge clk_i);
        #1;
        cyc++;
        ctrl_i.start = (job.poke_cyc != 8'd0) && (cyc == int'(job.poke_cyc));
        ctrl_i.base_addr = ctrl_i.start ? 32'hdead_0000 : job.base;
      end
    end
  endtask

  task automatic run_job(input int idx);
    job_t job;
    int   err_before;
    int   done_before;
    int   n_wr;
    job = jobs[idx];
    err_before = errors;
    done_before = done_total;
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_strb_q.delete();
    sent_data_q.delete();
    sent_strb_q.delete();
    cleared = 1'b0;
    @(negedge clk_i);
    check_bit(flags_o.ready_start, 1'b1, "flags_o.ready_start before start");
    @(posedge clk_i);
    #1;
    stall_pct = job.stall_pct;
    ctrl_i = '{1'b1, job.base, job.stride, job.length};
    fork
      send_beats(job);
      watch_job(job);
    join
    if (cleared) begin
      n_wr = wr_addr_q.size();
      repeat (20) @(posedge clk_i);
      @(negedge clk_i);
      check_len(len_t'(wr_addr_q.size()), len_t'(n_wr), "write count after clear");
      check_bit(flags_o.ready_start, 1'b1, "flags_o.ready_start after clear");
      check_bit(mem_req_o, 1'b0, "mem_req_o after clear");
      if (n_wr + 1 < int'(job.clear_at) || n_wr > int'(job.clear_at)) begin
        $display("ERROR: job %0d wrote %0d words before clear, but %0d beats were sent",
                 idx, n_wr, job.clear_at);
        errors++;
      end
    end else begin
      // The last write may still wait for its grant after done
      @(negedge clk_i);
      while (mem_req_o) @(negedge clk_i);
      check_len(len_t'(wr_addr_q.size()), job.length, "write count");
    end
    check_len(len_t'(done_total - done_before), len_t'(cleared ? 0 : 1), "done pulses");
    for (int i = 0; i < wr_addr_q.size() && i < sent_data_q.size(); i++) begin
      check_addr(wr_addr_q[i], predict_addr(job, i), $sformatf("mem addr of beat %0d", i));
      check_data(wr_data_q[i], sent_data_q[i], $sformatf("mem data of beat %0d", i));
      check_strb(wr_strb_q[i], sent_strb_q[i], $sformatf("mem strobe of beat %0d", i));
    end
    if (errors != err_before) begin
      tests_failed++;
    end
    $display("job %0d: base %h stride %h len %0d writes %0d%s: %s", idx, job.base,
             job.stride, job.length, wr_addr_q.size(), cleared ? " (cleared)" : "",
             (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = 100;
    for (int j = 0; j < NUM_JOBS; j++) begin
      limit += int'(jobs[j].length) * 20 + 100;
    end
    repeat (limit) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, a job did not finish", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    clear_i = 1'b0;
    enable_i = 1'b1;
    stream_valid_i = 1'b0;
    stream_beat_i = '0;
    mem_gnt_i = 1'b0;
    ctrl_i = '0;
    src_rng = SEED;
    mem_rng = SEED ^ 32'hffff_0000;
    stall_pct = 8'd0;
    hold_gnt = 1'b0;
    cleared = 1'b0;
    errors = 0;
    tests_failed = 0;
    done_total = 0;
    // base, stride, length, stall %, gap %, clear after beat, poke cycle
    jobs[0] = '{32'h0000_1000, 32'd4, 16'd8, 8'd0, 8'd0, 16'd0, 8'd0};
    jobs[1] = '{32'h0000_2000, 32'd16, 16'd12, 8'd30, 8'd30, 16'd0, 8'd4};
    jobs[2] = '{32'h0000_3001, 32'd0, 16'd5, 8'd20, 8'd0, 16'd0, 8'd0};
    jobs[3] = '{32'h0000_4000, 32'd0, 16'd0, 8'd0, 8'd0, 16'd0, 8'd0};
    jobs[4] = '{32'h0000_5000, 32'd8, 16'd20, 8'd50, 8'd10, 16'd7, 8'd0};
    jobs[5] = '{32'h8000_0000, 32'hffff_fffc, 16'd10, 8'd40, 8'd40, 16'd0, 8'd0};
    jobs[6] = '{32'h0000_6000, 32'd6, 16'd16, 8'd25, 8'd25, 16'd0, 8'd6};
    table_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    // ready_start is the top bit of the flags
    check_flags(flags_o, sink_flags_t'(3'b100), "flags_o after reset");
    check_bit(mem_req_o, 1'b0, "mem_req_o after reset");
    check_bit(stream_ready_o, 1'b0, "stream_ready_o after reset");
    if (errors != 0) begin
      tests_failed++;
    end
    $display("reset: %s", (errors == 0) ? "ok" : "FAILED");
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    assert_fails = i_dut.i_assert.fail_cnt;
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             NUM_JOBS + 1, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/sink_pkg.sv
source/sink_addr_gen.sv
source/sink_addr_fifo.sv
source/sink_ctrl_fsm.sv
source/sink_xfer_counter.sv
source/sink_req_stage.sv
source/sink_top.sv
bench/sink_assert.sv
bench/sink_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the streamer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
  --top-module sink_tb -o sink_sim > build.log 2>&1 \
  && ./obj_dir/sink_sim +verilator+error+limit+1000 > "$LOG" 2>&1 \
  || { cat build.log "$LOG" 2>/dev/null; echo "Build or run error"; exit 1; }

cat "$LOG"
grep -qx "Simulation passed" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
